// File: include/cb_defines.svh
`ifndef CB_DEFINES_SVH
`define CB_DEFINES_SVH

// Completion buffer depth, kept a power of two
`define CB_NUM_ENTRY 8

// Architectural integer registers
`define CB_NUM_REGS 32

// Load/store unit data memory, in 32-bit words
`define CB_MEM_WORDS 64

// Dispatch to result for a load, at least 2
`define CB_LOAD_LATENCY 3

`endif

// File: hw/cb_pkg.sv
`include "cb_defines.svh"

package cb_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [$clog2(`CB_NUM_ENTRY)-1:0] cb_idx_t;

  // Codes 5 to 15 are illegal
  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_XOR   = 4'd2,
    OP_LOAD  = 4'd3,
    OP_STORE = 4'd4
  } op_t;

  typedef enum logic [1:0] {
    NO_EXCEPTION  = 2'b00,
    ILLEGAL       = 2'b01,
    MAL_LOADSTORE = 2'b10
  } cb_exception_t;

  // Load/store unit FSM
  typedef enum logic {
    LS_IDLE,
    LS_BUSY
  } ls_state_t;

  // Slot is filled in by the top level from the buffer tail
  typedef struct packed {
    op_t      op;
    reg_idx_t rd;
    word_t    opa;
    word_t    opb;
    word_t    pc;
    cb_idx_t  slot;
  } dispatch_t;

  typedef struct packed {
    cb_idx_t       slot;
    reg_idx_t      rd;
    word_t         data;
    logic          wen;
    cb_exception_t exception;
  } result_t;

  typedef struct packed {
    reg_idx_t rd;
    word_t    data;
    logic     wen;
    word_t    pc;
  } commit_t;

endpackage

// File: hw/completion_buffer.sv
`timescale 1ns/1ps
`include "cb_defines.svh"

module completion_buffer (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  alloc_en,
  input  cb_pkg::word_t         alloc_pc,
  output cb_pkg::cb_idx_t       tail_idx,
  output logic                  full,
  input  logic                  arith_result_en,
  input  cb_pkg::result_t       arith_result,
  input  logic                  ls_result_en,
  input  cb_pkg::result_t       ls_result,
  output logic                  retire_en,
  output cb_pkg::reg_idx_t      retire_rd,
  output cb_pkg::word_t         retire_data,
  output logic                  commit_valid,
  output cb_pkg::commit_t       commit_data,
  output logic                  exception_valid,
  output cb_pkg::word_t         exception_pc,
  output cb_pkg::cb_exception_t exception_cause,
  output logic                  flush
);

  localparam int IW = $clog2(`CB_NUM_ENTRY);

  // One in-flight instruction
  typedef struct packed {
    logic                  done;
    cb_pkg::cb_exception_t exception;
    logic                  wen;
    cb_pkg::reg_idx_t      rd;
    cb_pkg::word_t         data;
    cb_pkg::word_t         pc;
  } cb_entry_t;

  cb_entry_t       slots [`CB_NUM_ENTRY];
  // Extra MSB tells full from empty
  logic [IW:0]     head;
  logic [IW:0]     tail;
  cb_pkg::cb_idx_t head_sel;
  cb_entry_t       head_entry;
  logic            move_head;
  logic            move_tail;

  // Merge a unit result into its slot, pc stays from allocation
  function automatic cb_entry_t fill_entry(cb_entry_t old, cb_pkg::result_t r);
    cb_entry_t e;
    e           = old;
    e.done      = 1'b1;
    e.exception = r.exception;
    e.wen       = r.wen;
    e.rd        = r.rd;
    e.data      = r.data;
    return e;
  endfunction

  assign head_sel   = head[IW-1:0];
  assign head_entry = slots[head_sel];
  assign tail_idx   = tail[IW-1:0];
  assign full       = (head[IW-1:0] == tail[IW-1:0]) && (head[IW] != tail[IW]);

  // Empty head slot is never done, so no empty check needed
  assign flush     = head_entry.done && (head_entry.exception != cb_pkg::NO_EXCEPTION);
  assign move_head = head_entry.done && !flush;
  assign move_tail = alloc_en && !full;

  // Register zero is never written
  assign retire_en   = move_head && head_entry.wen && (head_entry.rd != '0);
  assign retire_rd   = head_entry.rd;
  assign retire_data = head_entry.data;

  assign commit_valid = move_head;
  always_comb begin
    commit_data.rd   = head_entry.rd;
    commit_data.data = head_entry.data;
    commit_data.wen  = retire_en;
    commit_data.pc   = head_entry.pc;
  end

  assign exception_valid = flush;
  assign exception_pc    = head_entry.pc;
  assign exception_cause = head_entry.exception;

  // Head and tail pointers
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head <= '0;
      tail <= '0;
    end else if (flush) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (move_head) begin
        head <= head + 1'b1;
      end
      if (move_tail) begin
        tail <= tail + 1'b1;
      end
    end
  end

  // Slot array
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `CB_NUM_ENTRY; i++) begin
        slots[i] <= '0;
      end
    end else if (flush) begin
      // Drop head and every younger entry
      for (int i = 0; i < `CB_NUM_ENTRY; i++) begin
        slots[i] <= '0;
      end
    end else begin
      if (move_head) begin
        slots[head_sel] <= '0;
      end
      // New entry waits for its result
      if (move_tail) begin
        slots[tail_idx] <= '{done: 1'b0, exception: cb_pkg::NO_EXCEPTION, wen: 1'b0,
                             rd: '0, data: '0, pc: alloc_pc};
      end
      // Units always target different slots
      if (arith_result_en) begin
        slots[arith_result.slot] <= fill_entry(slots[arith_result.slot], arith_result);
      end
      if (ls_result_en) begin
        slots[ls_result.slot] <= fill_entry(slots[ls_result.slot], ls_result);
      end
    end
  end

endmodule

// File: hw/arith_unit.sv
`timescale 1ns/1ps

module arith_unit (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              alloc_en,
  input  cb_pkg::dispatch_t alloc_op,
  input  logic              flush,
  output logic              result_en,
  output cb_pkg::result_t   result
);

  cb_pkg::result_t next_result;

  // Compute result for the dispatched op
  always_comb begin
    next_result.slot      = alloc_op.slot;
    next_result.rd        = alloc_op.rd;
    next_result.wen       = 1'b1;
    next_result.exception = cb_pkg::NO_EXCEPTION;
    case (alloc_op.op)
      cb_pkg::OP_ADD: next_result.data = alloc_op.opa + alloc_op.opb;
      cb_pkg::OP_SUB: next_result.data = alloc_op.opa - alloc_op.opb;
      cb_pkg::OP_XOR: next_result.data = alloc_op.opa ^ alloc_op.opb;
      default: begin
        // Unknown code, no register write
        next_result.data      = '0;
        next_result.wen       = 1'b0;
        next_result.exception = cb_pkg::ILLEGAL;
      end
    endcase
  end

  // Result strobe, dropped on flush
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      result_en <= 1'b0;
    end else begin
      result_en <= alloc_en && !flush;
    end
  end

  // Payload only loads on a dispatch
  always_ff @(posedge CLK) begin
    if (alloc_en) begin
      result <= next_result;
    end
  end

endmodule

// File: hw/load_store_unit.sv
`timescale 1ns/1ps
`include "cb_defines.svh"

module load_store_unit (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              alloc_en,
  input  cb_pkg::dispatch_t alloc_op,
  input  logic              flush,
  output logic              busy,
  output logic              result_en,
  output cb_pkg::result_t   result
);

  localparam int MW = $clog2(`CB_MEM_WORDS);
  localparam int CW = $clog2(`CB_LOAD_LATENCY) + 1;
  localparam logic [CW-1:0] CNT_INIT = CW'(`CB_LOAD_LATENCY - 1);

  cb_pkg::ls_state_t state;
  logic [CW-1:0]     cnt;
  cb_pkg::word_t     mem [`CB_MEM_WORDS];
  logic [MW-1:0]     word_idx;
  logic [MW-1:0]     ld_idx;
  logic              aligned;
  logic              is_load;

  // Address is operand a, byte addressed
  assign word_idx = alloc_op.opa[MW+1:2];
  assign aligned  = (alloc_op.opa[1:0] == 2'b00);
  assign is_load  = (alloc_op.op == cb_pkg::OP_LOAD);
  assign busy     = (state == cb_pkg::LS_BUSY);

  // FSM, latency counter and memory
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= cb_pkg::LS_IDLE;
      cnt       <= '0;
      result_en <= 1'b0;
      for (int i = 0; i < `CB_MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      result_en <= 1'b0;
      if (flush) begin
        state <= cb_pkg::LS_IDLE;
      end else if (state == cb_pkg::LS_BUSY) begin
        if (cnt == CW'(1)) begin
          state     <= cb_pkg::LS_IDLE;
          result_en <= 1'b1;
        end else begin
          cnt <= cnt - 1'b1;
        end
      end else if (alloc_en) begin
        if (aligned && is_load) begin
          state <= cb_pkg::LS_BUSY;
          cnt   <= CNT_INIT;
        end else begin
          // Store or misaligned access answers next cycle
          result_en <= 1'b1;
          if (aligned) begin
            mem[word_idx] <= alloc_op.opb;
          end
        end
      end
    end
  end

  // Result payload, load data sampled while counting
  always_ff @(posedge CLK) begin
    if (state == cb_pkg::LS_BUSY) begin
      result.data <= mem[ld_idx];
    end else if (alloc_en) begin
      ld_idx           <= word_idx;
      result.slot      <= alloc_op.slot;
      result.rd        <= alloc_op.rd;
      result.data      <= '0;
      result.wen       <= aligned && is_load;
      result.exception <= aligned ? cb_pkg::NO_EXCEPTION : cb_pkg::MAL_LOADSTORE;
    end
  end

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps
`include "cb_defines.svh"

module reg_file (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             wen,
  input  cb_pkg::reg_idx_t wsel,
  input  cb_pkg::word_t    wdata,
  input  cb_pkg::reg_idx_t rsel,
  output cb_pkg::word_t    rdata
);

  cb_pkg::word_t regs [`CB_NUM_REGS];

  // Written only at retirement
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `CB_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (wsel != '0)) begin
      // x0 stays zero
      regs[wsel] <= wdata;
    end
  end

  // Read port for the issue side
  assign rdata = regs[rsel];

endmodule

// File: hw/commit_core_top.sv
`timescale 1ns/1ps

module commit_core_top (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  dispatch_en,
  input  cb_pkg::dispatch_t     dispatch_op,
  output logic                  dispatch_full,
  output logic                  commit_valid,
  output cb_pkg::commit_t       commit_data,
  output logic                  exception_valid,
  output cb_pkg::word_t         exception_pc,
  output cb_pkg::cb_exception_t exception_cause
);

  cb_pkg::dispatch_t routed;
  cb_pkg::cb_idx_t   tail_idx;
  cb_pkg::result_t   arith_result;
  cb_pkg::result_t   ls_result;
  cb_pkg::reg_idx_t  retire_rd;
  cb_pkg::word_t     retire_data;
  logic              cb_full;
  logic              flush;
  logic              ls_busy;
  logic              is_ls;
  logic              accept;
  logic              arith_result_en;
  logic              ls_result_en;
  logic              retire_en;

  // Dispatch takes the slot at the buffer tail
  always_comb begin
    routed      = dispatch_op;
    routed.slot = tail_idx;
  end

  // Loads and stores go to the LSU, everything else incl. illegal to ALU
  assign is_ls = (dispatch_op.op == cb_pkg::OP_LOAD) || (dispatch_op.op == cb_pkg::OP_STORE);

  // Refuse on full buffer, busy LSU, or during a flush
  assign dispatch_full = cb_full || flush || (is_ls && ls_busy);
  assign accept        = dispatch_en && !dispatch_full;

  completion_buffer cb0 (
    .CLK(CLK), .nRST(nRST),
    .alloc_en(accept), .alloc_pc(dispatch_op.pc),
    .tail_idx(tail_idx), .full(cb_full),
    .arith_result_en(arith_result_en), .arith_result(arith_result),
    .ls_result_en(ls_result_en), .ls_result(ls_result),
    .retire_en(retire_en), .retire_rd(retire_rd), .retire_data(retire_data),
    .commit_valid(commit_valid), .commit_data(commit_data),
    .exception_valid(exception_valid), .exception_pc(exception_pc),
    .exception_cause(exception_cause), .flush(flush)
  );

  arith_unit alu0 (
    .CLK(CLK), .nRST(nRST), .alloc_en(accept && !is_ls), .alloc_op(routed),
    .flush(flush), .result_en(arith_result_en), .result(arith_result)
  );

  load_store_unit lsu0 (
    .CLK(CLK), .nRST(nRST), .alloc_en(accept && is_ls), .alloc_op(routed),
    .flush(flush), .busy(ls_busy), .result_en(ls_result_en), .result(ls_result)
  );

  // Read side unused until an issue stage exists
  reg_file rf0 (
    .CLK(CLK), .nRST(nRST), .wen(retire_en), .wsel(retire_rd), .wdata(retire_data),
    .rsel('0), .rdata()
  );

endmodule

// File: tb/tb_commit_core.sv
`timescale 1ns/1ps

module tb_commit_core;

  localparam int TIMEOUT = 2000;

  // Golden dispatch and its gap flag (0 random gap, 1 no gap, 2 drain first)
  typedef struct packed {
    logic [1:0]        flag;
    logic [31:0]       need;
    cb_pkg::dispatch_t op;
  } stim_t;

  // Expected commit or exception in retirement order
  typedef struct packed {
    logic                  is_exc;
    cb_pkg::commit_t       commit;
    cb_pkg::word_t         exc_pc;
    cb_pkg::cb_exception_t cause;
  } expect_t;

  // Register value checked once the run has drained
  typedef struct packed {
    cb_pkg::reg_idx_t rd;
    cb_pkg::word_t    value;
  } reg_check_t;

  logic                  CLK;
  logic                  nRST;
  logic                  dispatch_en;
  cb_pkg::dispatch_t     dispatch_op;
  logic                  dispatch_full;
  logic                  commit_valid;
  cb_pkg::commit_t       commit_data;
  logic                  exception_valid;
  cb_pkg::word_t         exception_pc;
  cb_pkg::cb_exception_t exception_cause;

  stim_t      stim_q[$];
  expect_t    exp_q[$];
  reg_check_t reg_q[$];
  int         matched;

  commit_core_top dut0 (
    .CLK(CLK), .nRST(nRST),
    .dispatch_en(dispatch_en), .dispatch_op(dispatch_op), .dispatch_full(dispatch_full),
    .commit_valid(commit_valid), .commit_data(commit_data),
    .exception_valid(exception_valid), .exception_pc(exception_pc),
    .exception_cause(exception_cause)
  );

  // 8 ns clock
  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // Parses D, C, E and R lines and skips all others
  task automatic load_golden();
    int         fd;
    int         n;
    int         want;
    string      line;
    logic [31:0] v0, v1, v2, v3, v4, v5;
    stim_t      s;
    expect_t    e;
    reg_check_t r;
    fd = $fopen("tb/commit_golden.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open golden file tb/commit_golden.txt");
    end
    while ($fgets(line, fd) != 0) begin
      n    = 0;
      want = 0;
      s    = '0;
      e    = '0;
      r    = '0;
      case (line[0])
        "D": begin
          want = 6;
          n = $sscanf(line, "D %h %h %h %h %h %h", v0, v1, v2, v3, v4, v5);
          s.flag    = v0[1:0];
          // Expected lines that must be matched before a drain dispatch
          s.need    = exp_q.size();
          s.op.op   = cb_pkg::op_t'(v1[3:0]);
          s.op.rd   = v2[4:0];
          s.op.opa  = v3;
          s.op.opb  = v4;
          s.op.pc   = v5;
          stim_q.push_back(s);
        end
        "C": begin
          want = 4;
          n = $sscanf(line, "C %h %h %h %h", v0, v1, v2, v3);
          e.commit.rd   = v0[4:0];
          e.commit.data = v1;
          e.commit.wen  = v2[0];
          e.commit.pc   = v3;
          exp_q.push_back(e);
        end
        "E": begin
          want = 2;
          n = $sscanf(line, "E %h %h", v0, v1);
          e.is_exc = 1'b1;
          e.exc_pc = v0;
          e.cause  = cb_pkg::cb_exception_t'(v1[1:0]);
          exp_q.push_back(e);
        end
        "R": begin
          want = 2;
          n = $sscanf(line, "R %h %h", v0, v1);
          r.rd    = v0[4:0];
          r.value = v1;
          reg_q.push_back(r);
        end
        default: ;
      endcase
      if (n != want) begin
        abort_run($sformatf("Malformed golden line: %s", line));
      end
    end
    $fclose(fd);
  endtask

  // Blocks until the monitor has matched the given number of expected lines
  task automatic wait_retired(input int need);
    int cycles;
    cycles = 0;
    while (matched < need) begin
      @(posedge CLK);
      #1;
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("Timeout waiting for expected commits and exceptions");
      end
    end
  endtask

  // Offer one dispatch and hold it until dispatch_full is low at an edge
  task automatic send(input stim_t s);
    int   gap;
    int   cycles;
    logic refused;
    gap     = 0;
    cycles  = 0;
    refused = 1'b1;
    if (s.flag == 2'd2) begin
      wait_retired(s.need);
    end else if (s.flag == 2'd0) begin
      gap = $urandom % 3;
    end
    repeat (gap) begin
      @(posedge CLK);
      #1;
    end
    dispatch_op = s.op;
    dispatch_en = 1'b1;
    while (refused) begin
      @(negedge CLK);
      refused = dispatch_full;
      @(posedge CLK);
      #1;
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("Timeout waiting for a dispatch to be accepted");
      end
    end
    dispatch_en = 1'b0;
    dispatch_op = '0;
  endtask

  // Match one retirement pulse against the next expected line
  task automatic check_event();
    expect_t e;
    if (exp_q.size() == 0) begin
      abort_run("Commit or exception pulse with no expected line left");
    end else begin
      e = exp_q.pop_front();
      if (e.is_exc) begin
        check_value("exception_valid", 32'(exception_valid), 32'd1);
        check_value("commit_valid", 32'(commit_valid), 32'd0);
        check_value("exception_pc", exception_pc, e.exc_pc);
        check_value("exception_cause", 32'(exception_cause), 32'(e.cause));
      end else begin
        check_value("commit_valid", 32'(commit_valid), 32'd1);
        check_value("exception_valid", 32'(exception_valid), 32'd0);
        check_value("commit_data.rd", 32'(commit_data.rd), 32'(e.commit.rd));
        check_value("commit_data.data", commit_data.data, e.commit.data);
        check_value("commit_data.wen", 32'(commit_data.wen), 32'(e.commit.wen));
        check_value("commit_data.pc", commit_data.pc, e.commit.pc);
      end
      matched++;
    end
  endtask

  // Outputs are sampled mid-cycle
  always @(negedge CLK) begin
    if (nRST && (commit_valid || exception_valid)) begin
      check_event();
    end
  end

  initial begin
    int total;
    void'($urandom(96));
    nRST        = 1'b0;
    dispatch_en = 1'b0;
    dispatch_op = '0;
    matched     = 0;
    load_golden();
    total = exp_q.size();
    repeat (10) @(posedge CLK);
    #1;
    nRST = 1'b1;
    // Empty buffer and idle LSU accept right out of reset
    check_value("dispatch_full", 32'(dispatch_full), 32'd0);
    foreach (stim_q[i]) begin
      send(stim_q[i]);
    end
    wait_retired(total);
    // Idle stretch so a stray pulse still reaches the monitor
    repeat (10) @(posedge CLK);
    #1;
    foreach (reg_q[i]) begin
      check_value($sformatf("rf0.regs[%0d]", reg_q[i].rd), dut0.rf0.regs[reg_q[i].rd],
                  reg_q[i].value);
    end
    $display("All checks passed");
    $finish;
  end

endmodule

// File: tb/commit_golden.txt
# D flag op rd opa opb pc (flag 0 random gap, 1 no gap, 2 after all earlier lines retire)
# C rd data wen pc / E pc cause / R rd value after the run, all fields hex
D 0 0 01 00000005 00000003 00000100
C 01 00000008 1 00000100
D 0 1 02 00000010 00000003 00000104
C 02 0000000d 1 00000104
D 0 2 03 0000ff00 00000f0f 00000108
C 03 0000f00f 1 00000108
D 0 4 00 00000010 cafef00d 0000010c
C 00 00000000 0 0000010c
D 0 3 04 00000010 00000000 00000110
D 1 0 05 00000001 00000001 00000114
C 04 cafef00d 1 00000110
C 05 00000002 1 00000114
D 0 0 00 00000007 00000007 00000118
C 00 0000000e 0 00000118
D 2 9 06 00000001 00000002 0000011c
D 1 0 07 00000003 00000003 00000120
E 0000011c 1
D 0 1 08 00000009 0000000a 00000124
C 08 ffffffff 1 00000124
D 2 3 09 00000012 00000000 00000128
D 1 2 0a 00000003 00000005 0000012c
E 00000128 2
D 0 2 0a 12345678 ffffffff 00000130
C 0a edcba987 1 00000130
D 0 0 0b 00000001 00000100 00000134
D 1 0 0c 00000002 00000100 00000138
D 1 0 0d 00000003 00000100 0000013c
D 1 0 0e 00000004 00000100 00000140
D 1 0 0f 00000005 00000100 00000144
D 1 0 10 00000006 00000100 00000148
D 1 0 11 00000007 00000100 0000014c
D 1 0 12 00000008 00000100 00000150
D 1 0 13 00000009 00000100 00000154
C 0b 00000101 1 00000134
C 0c 00000102 1 00000138
C 0d 00000103 1 0000013c
C 0e 00000104 1 00000140
C 0f 00000105 1 00000144
C 10 00000106 1 00000148
C 11 00000107 1 0000014c
C 12 00000108 1 00000150
C 13 00000109 1 00000154
R 00 00000000
R 04 cafef00d
R 07 00000000
R 0a edcba987
R 13 00000109

// File: verilog.f
+incdir+include
hw/cb_pkg.sv
hw/completion_buffer.sv
hw/arith_unit.sv
hw/load_store_unit.sv
hw/reg_file.sv
hw/commit_core_top.sv
tb/tb_commit_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_commit_core
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
